/* rtl/hand_pkg.sv */
package hand_pkg;

    // Coordinate width shared by all position ports
    localparam int coord_w = 12;

    // Screen wrap limits
    localparam int max_x = 1024;
    localparam int max_y = 768;

    localparam int reset_x = 512;
    localparam int reset_y = 384;  // Bottom corner

    // Top corner sits this many rows above the bottom corner
    localparam int hand_span = 64;

    localparam int num_buttons = 4;

    // Bit positions in the button vector
    localparam int btn_left = 0;
    localparam int btn_right = 1;
    localparam int btn_up = 2;
    localparam int btn_down = 3;

endpackage

/* rtl/button_debounce.sv */
module button_debounce #(
    parameter int WIDTH = 4,
    parameter int DEBOUNCE_CYCLES = 500000
) (
    input  logic             clk_in,
    input  logic             rst_in,
    input  logic [WIDTH-1:0] raw,
    output logic [WIDTH-1:0] clean
);

    localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);
    localparam logic [CNT_W-1:0] CNT_DONE = CNT_W'(DEBOUNCE_CYCLES);

    logic [WIDTH-1:0] sync_a;
    logic [WIDTH-1:0] sync_b;
    logic [CNT_W-1:0] stable_cnt [WIDTH];

    // Two-flop synchronizer for the asynchronous buttons
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            sync_a <= '0;
            sync_b <= '0;
        end else begin
            sync_a <= raw;
            sync_b <= sync_a;
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            clean <= '0;
            for (int i = 0; i < WIDTH; i++) begin
                stable_cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < WIDTH; i++) begin
                if (sync_b[i] == clean[i]) begin
                    stable_cnt[i] <= '0;            // Nothing pending
                end else if (stable_cnt[i] == CNT_DONE) begin
                    clean[i] <= sync_b[i];
                    stable_cnt[i] <= '0;
                end else begin
                    stable_cnt[i] <= stable_cnt[i] + 1'b1;
                end
            end
        end
    end

endmodule

/* rtl/hand_controller.sv */
module hand_controller #(
    parameter int MOVE_PERIOD = 1625000,
    parameter int MOVE_STEP = 16
) (
    input  logic                             clk_in,
    input  logic                             rst_in,
    input  logic [hand_pkg::num_buttons-1:0] buttons_clean,
    output logic [hand_pkg::coord_w-1:0]     bottom_x,
    output logic [hand_pkg::coord_w-1:0]     bottom_y,
    output logic [hand_pkg::coord_w-1:0]     top_x,
    output logic [hand_pkg::coord_w-1:0]     top_y,
    output logic                             pos_changed
);

    localparam int CW = hand_pkg::coord_w;
    localparam int DW = CW + 2;  // Room for sign and overflow
    localparam int CNT_W = (MOVE_PERIOD > 1) ? $clog2(MOVE_PERIOD) : 1;

    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(MOVE_PERIOD - 1);
    localparam logic signed [DW-1:0] STEP = DW'(MOVE_STEP);
    localparam logic signed [DW-1:0] LIM_X = DW'(hand_pkg::max_x);
    localparam logic signed [DW-1:0] LIM_Y = DW'(hand_pkg::max_y);

    localparam logic [CW-1:0] RST_X = CW'(hand_pkg::reset_x);
    localparam logic [CW-1:0] RST_BOT_Y = CW'(hand_pkg::reset_y);
    localparam logic [CW-1:0] RST_TOP_Y = CW'(hand_pkg::reset_y - hand_pkg::hand_span);

    logic [CNT_W-1:0] move_cnt;
    logic move_now;

    logic signed [DW-1:0] dx;
    logic signed [DW-1:0] dy;

    logic [CW-1:0] next_bottom_x;
    logic [CW-1:0] next_bottom_y;
    logic [CW-1:0] next_top_x;
    logic [CW-1:0] next_top_y;
    logic any_move;

    // Step one coordinate and wrap at either screen edge
    function automatic logic [CW-1:0] wrap_step(
        input logic [CW-1:0] pos,
        input logic signed [DW-1:0] delta,
        input logic signed [DW-1:0] limit
    );
        logic signed [DW-1:0] sum;
        logic signed [DW-1:0] res;
        sum = $signed({2'b00, pos}) + delta;
        if (sum >= limit) begin
            res = delta;
        end else if (sum < 0) begin
            res = limit + delta;
        end else begin
            res = sum;
        end
        return res[CW-1:0];
    endfunction

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            move_cnt <= '0;
        end else if (move_cnt == CNT_LAST) begin
            move_cnt <= '0;
        end else begin
            move_cnt <= move_cnt + 1'b1;
        end
    end

    assign move_now = (move_cnt == '0);

    // Left beats right, up beats down; up is negative y
    always_comb begin
        dx = '0;
        dy = '0;
        if (buttons_clean[hand_pkg::btn_left]) begin
            dx = -STEP;
        end else if (buttons_clean[hand_pkg::btn_right]) begin
            dx = STEP;
        end
        if (buttons_clean[hand_pkg::btn_up]) begin
            dy = -STEP;
        end else if (buttons_clean[hand_pkg::btn_down]) begin
            dy = STEP;
        end
    end

    assign next_bottom_x = wrap_step(bottom_x, dx, LIM_X);
    assign next_bottom_y = wrap_step(bottom_y, dy, LIM_Y);
    assign next_top_x = wrap_step(top_x, dx, LIM_X);
    assign next_top_y = wrap_step(top_y, dy, LIM_Y);

    assign any_move = (next_bottom_x != bottom_x) || (next_bottom_y != bottom_y) ||
                      (next_top_x != top_x) || (next_top_y != top_y);

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            bottom_x <= RST_X;
            bottom_y <= RST_BOT_Y;
            top_x <= RST_X;
            top_y <= RST_TOP_Y;
            pos_changed <= 1'b0;
        end else begin
            pos_changed <= move_now && any_move;  // Lines up with the new coordinates
            if (move_now) begin
                bottom_x <= next_bottom_x;
                bottom_y <= next_bottom_y;
                top_x <= next_top_x;
                top_y <= next_top_y;
            end
        end
    end

endmodule

/* rtl/hand_report.sv */
module hand_report (
    input  logic                         clk_in,
    input  logic                         rst_in,
    input  logic [hand_pkg::coord_w-1:0] bottom_x,
    input  logic [hand_pkg::coord_w-1:0] bottom_y,
    input  logic [hand_pkg::coord_w-1:0] top_x,
    input  logic [hand_pkg::coord_w-1:0] top_y,
    input  logic                         pos_changed,
    input  logic                         report_ack,
    output logic                         report_req,
    output logic [hand_pkg::coord_w-1:0] report_bottom_x,
    output logic [hand_pkg::coord_w-1:0] report_bottom_y,
    output logic [hand_pkg::coord_w-1:0] report_top_x,
    output logic [hand_pkg::coord_w-1:0] report_top_y
);

    localparam int CW = hand_pkg::coord_w;

    typedef enum logic [1:0] {
        st_idle,
        st_wait_high,
        st_wait_low
    } state_t;

    state_t state;
    logic pending;  // A change arrived while a transfer was busy

    assign report_req = (state == st_wait_high);

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state <= st_idle;
            pending <= 1'b0;
            report_bottom_x <= CW'(hand_pkg::reset_x);
            report_bottom_y <= CW'(hand_pkg::reset_y);
            report_top_x <= CW'(hand_pkg::reset_x);
            report_top_y <= CW'(hand_pkg::reset_y - hand_pkg::hand_span);
        end else begin
            case (state)
                st_idle: begin
                    if (pos_changed) begin
                        report_bottom_x <= bottom_x;
                        report_bottom_y <= bottom_y;
                        report_top_x <= top_x;
                        report_top_y <= top_y;
                        state <= st_wait_high;
                    end
                end
                st_wait_high: begin
                    if (pos_changed) pending <= 1'b1;
                    if (report_ack) state <= st_wait_low;  // Drops req
                end
                st_wait_low: begin
                    if (!report_ack) begin
                        if (pending || pos_changed) begin
                            // Newest position only, intermediate steps are lost
                            report_bottom_x <= bottom_x;
                            report_bottom_y <= bottom_y;
                            report_top_x <= top_x;
                            report_top_y <= top_y;
                            pending <= 1'b0;
                            state <= st_wait_high;
                        end else begin
                            state <= st_idle;
                        end
                    end else if (pos_changed) begin
                        pending <= 1'b1;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

/* rtl/hand_top.sv */
module hand_top #(
    parameter int DEBOUNCE_CYCLES = 500000,
    parameter int MOVE_PERIOD = 1625000,  // 25 ms at 65 MHz
    parameter int MOVE_STEP = 16
) (
    input  logic                             clk_in,
    input  logic                             rst_in,
    input  logic [hand_pkg::num_buttons-1:0] buttons,
    input  logic                             report_ack,
    output logic                             report_req,
    output logic [hand_pkg::coord_w-1:0]     report_bottom_x,
    output logic [hand_pkg::coord_w-1:0]     report_bottom_y,
    output logic [hand_pkg::coord_w-1:0]     report_top_x,
    output logic [hand_pkg::coord_w-1:0]     report_top_y
);

    logic [hand_pkg::num_buttons-1:0] buttons_clean;

    // Live corner positions
    logic [hand_pkg::coord_w-1:0] bottom_x;
    logic [hand_pkg::coord_w-1:0] bottom_y;
    logic [hand_pkg::coord_w-1:0] top_x;
    logic [hand_pkg::coord_w-1:0] top_y;
    logic pos_changed;

    button_debounce #(
        .WIDTH(hand_pkg::num_buttons),
        .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
    ) debounce_inst (
        .clk_in(clk_in),
        .rst_in(rst_in),
        .raw(buttons),
        .clean(buttons_clean)
    );

    hand_controller #(
        .MOVE_PERIOD(MOVE_PERIOD),
        .MOVE_STEP(MOVE_STEP)
    ) controller_inst (
        .clk_in(clk_in),
        .rst_in(rst_in),
        .buttons_clean(buttons_clean),
        .bottom_x(bottom_x),
        .bottom_y(bottom_y),
        .top_x(top_x),
        .top_y(top_y),
        .pos_changed(pos_changed)
    );

    hand_report report_inst (
        .clk_in(clk_in),
        .rst_in(rst_in),
        .bottom_x(bottom_x),
        .bottom_y(bottom_y),
        .top_x(top_x),
        .top_y(top_y),
        .pos_changed(pos_changed),
        .report_ack(report_ack),
        .report_req(report_req),
        .report_bottom_x(report_bottom_x),
        .report_bottom_y(report_bottom_y),
        .report_top_x(report_top_x),
        .report_top_y(report_top_y)
    );

endmodule

/* tb/hand_tb.sv */
module hand_tb;

    timeunit 1ns;
    timeprecision 1ns;

    localparam int DEBOUNCE_CYCLES = 4;
    localparam int MOVE_PERIOD = 64;
    localparam int MOVE_STEP = 16;
    localparam int CW = hand_pkg::coord_w;

    localparam int RESET_X = 512;
    localparam int RESET_BOTTOM_Y = 384;
    localparam int RESET_TOP_Y = 320;

    // Screen wrap limits of the model
    localparam int MAX_X = 1024;
    localparam int MAX_Y = 768;

    localparam int REPORT_WAIT = 4 * MOVE_PERIOD;   // Debounce plus one full move period
    localparam int QUIET_CYCLES = 3 * MOVE_PERIOD;
    localparam int ACK_WAIT = 16;
    localparam int MAX_TRAILING = 4;
    localparam int MAX_LINES = 64;

    logic clk_in;
    logic rst_in;
    logic [hand_pkg::num_buttons-1:0] buttons;
    logic report_ack;
    logic report_req;
    logic [CW-1:0] report_bottom_x;
    logic [CW-1:0] report_bottom_y;
    logic [CW-1:0] report_top_x;
    logic [CW-1:0] report_top_y;

    // Three words per line: mask, report count, ack delay
    logic [15:0] pattern_mem [0:3*MAX_LINES-1];

    // Last reported corners
    int exp_bx;
    int exp_by;
    int exp_tx;
    int exp_ty;

    // Corners of the report under check
    int seen_bx;
    int seen_by;
    int seen_tx;
    int seen_ty;

    int value_errors;
    int proto_errors;
    int other_errors;
    int reports_checked;
    bit timed_out;

    logic prev_req;
    logic prev_ack;
    logic [CW-1:0] prev_bx;
    logic [CW-1:0] prev_by;
    logic [CW-1:0] prev_tx;
    logic [CW-1:0] prev_ty;

    hand_top #(
        .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES),
        .MOVE_PERIOD(MOVE_PERIOD),
        .MOVE_STEP(MOVE_STEP)
    ) UUT (
        .clk_in(clk_in),
        .rst_in(rst_in),
        .buttons(buttons),
        .report_ack(report_ack),
        .report_req(report_req),
        .report_bottom_x(report_bottom_x),
        .report_bottom_y(report_bottom_y),
        .report_top_x(report_top_x),
        .report_top_y(report_top_y)
    );

    initial begin
        clk_in = 1'b0;
        forever #50 clk_in = ~clk_in;
    end

    // Wrap rule: at or past the limit gives delta, below zero gives limit + delta
    function automatic int wrap_coord(input int pos, input int delta, input int limit);
        int n;
        n = pos + delta;
        if (n >= limit) begin
            return delta;
        end else if (n < 0) begin
            return limit + delta;
        end
        return n;
    endfunction

    // The negative-direction button wins when both of a pair are held
    function automatic int step_delta(input logic [3:0] mask, input int neg_bit,
                                      input int pos_bit);
        int d;
        d = 0;
        if (mask[neg_bit]) begin
            d = -MOVE_STEP;
        end else if (mask[pos_bit]) begin
            d = MOVE_STEP;
        end
        return d;
    endfunction

    // Number of steps from the last report to the seen one, 0 if none up to max_k
    function automatic int find_steps(input logic [3:0] mask, input int max_k);
        int bx;
        int by;
        int tx;
        int ty;
        int dx;
        int dy;
        int k;
        bx = exp_bx;
        by = exp_by;
        tx = exp_tx;
        ty = exp_ty;
        dx = step_delta(mask, hand_pkg::btn_left, hand_pkg::btn_right);
        dy = step_delta(mask, hand_pkg::btn_up, hand_pkg::btn_down);
        for (k = 1; k <= max_k; k++) begin
            bx = wrap_coord(bx, dx, MAX_X);
            by = wrap_coord(by, dy, MAX_Y);
            tx = wrap_coord(tx, dx, MAX_X);
            ty = wrap_coord(ty, dy, MAX_Y);
            if (bx == seen_bx && by == seen_by && tx == seen_tx && ty == seen_ty) begin
                return k;
            end
        end
        return 0;
    endfunction

    task automatic check_reset_state();
        if (report_req !== 1'b0) begin
            $display("ERROR at %0t ns: report_req is not low after reset", $time);
            value_errors++;
        end
        if (int'(report_bottom_x) != RESET_X || int'(report_bottom_y) != RESET_BOTTOM_Y ||
            int'(report_top_x) != RESET_X || int'(report_top_y) != RESET_TOP_Y) begin
            $display("ERROR at %0t ns: reset report shows bottom %0d/%0d top %0d/%0d", $time,
                     report_bottom_x, report_bottom_y, report_top_x, report_top_y);
            value_errors++;
        end
    endtask

    task automatic check_report(input logic [3:0] mask, input int max_k);
        if (find_steps(mask, max_k) == 0) begin
            $display("ERROR at %0t ns: report %0d/%0d %0d/%0d is not 1..%0d steps of mask %b",
                     $time, seen_bx, seen_by, seen_tx, seen_ty, max_k, mask);
            $display("  previous report was bottom %0d/%0d top %0d/%0d",
                     exp_bx, exp_by, exp_tx, exp_ty);
            value_errors++;
        end
        exp_bx = seen_bx;  // Follow the DUT so one miss does not cascade
        exp_by = seen_by;
        exp_tx = seen_tx;
        exp_ty = seen_ty;
        reports_checked++;
    endtask

    // Waits for req, captures the data, answers with ack and finishes the handshake
    task automatic take_report(input int ack_delay, input int limit, output bit got);
        int waited;
        got = 1'b0;
        waited = 0;
        while (!got && waited < limit) begin
            @(posedge clk_in);
            waited++;
            if (report_req) got = 1'b1;
        end
        if (got) begin
            seen_bx = int'(report_bottom_x);
            seen_by = int'(report_bottom_y);
            seen_tx = int'(report_top_x);
            seen_ty = int'(report_top_y);
            repeat (ack_delay) @(posedge clk_in);
            report_ack <= 1'b1;
            waited = 0;
            while (report_req && waited < ACK_WAIT) begin
                @(posedge clk_in);
                waited++;
            end
            if (report_req) begin
                $display("Timeout at %0t ns: req stayed high after ack was raised", $time);
                other_errors++;
                timed_out = 1'b1;
            end
            report_ack <= 1'b0;
        end
    endtask

    // Collects reports after release until the quiet window passes
    task automatic drain_trailing(input logic [3:0] mask, input int max_k);
        bit got;
        int trailing;
        trailing = 0;
        got = 1'b1;
        while (got && !timed_out) begin
            take_report(0, QUIET_CYCLES, got);
            if (got) begin
                trailing++;
                if (mask == 4'b0000) begin
                    $display("ERROR at %0t ns: report %0d/%0d %0d/%0d came with no button held",
                             $time, seen_bx, seen_by, seen_tx, seen_ty);
                    value_errors++;
                    exp_bx = seen_bx;
                    exp_by = seen_by;
                    exp_tx = seen_tx;
                    exp_ty = seen_ty;
                end else begin
                    check_report(mask, max_k);
                end
                if (trailing > MAX_TRAILING) begin
                    $display("Reports kept arriving after the buttons were released");
                    other_errors++;
                    got = 1'b0;
                end
            end
        end
    endtask

    task automatic run_line(input logic [3:0] mask, input int count, input int ack_delay);
        bit got;
        int i;
        int max_k;
        max_k = (ack_delay == 0) ? 1 : 64;  // Prompt ack sees every single step
        buttons <= mask;
        for (i = 0; i < count && !timed_out; i++) begin
            take_report(ack_delay, REPORT_WAIT, got);
            if (!got) begin
                $display("Timeout at %0t ns: report %0d of %0d never came for button mask %b",
                         $time, i + 1, count, mask);
                other_errors++;
                timed_out = 1'b1;
            end else begin
                check_report(mask, max_k);
            end
        end
        buttons <= '0;
        if (!timed_out) drain_trailing(mask, max_k);
    endtask

    // Handshake order and data stability
    always @(posedge clk_in) begin
        if (rst_in) begin
            prev_req <= 1'b0;
            prev_ack <= 1'b0;
        end else begin
            if (report_req && prev_req &&
                (report_bottom_x != prev_bx || report_bottom_y != prev_by ||
                 report_top_x != prev_tx || report_top_y != prev_ty)) begin
                $display("Handshake violation at %0t ns: report data changed while req was high",
                         $time);
                proto_errors++;
            end
            if (report_req && !prev_req && prev_ack) begin
                $display("Handshake violation at %0t ns: req rose again before ack went low",
                         $time);
                proto_errors++;
            end
            prev_req <= report_req;
            prev_ack <= report_ack;
            prev_bx <= report_bottom_x;
            prev_by <= report_bottom_y;
            prev_tx <= report_top_x;
            prev_ty <= report_top_y;
        end
    end

    initial begin
        int i;
        int line_idx;
        logic [3:0] line_mask;
        int line_count;
        int line_delay;
        rst_in = 1'b1;
        buttons = '0;
        report_ack = 1'b0;
        value_errors = 0;
        proto_errors = 0;
        other_errors = 0;
        reports_checked = 0;
        timed_out = 1'b0;
        exp_bx = RESET_X;
        exp_by = RESET_BOTTOM_Y;
        exp_tx = RESET_X;
        exp_ty = RESET_TOP_Y;
        for (i = 0; i < 3 * MAX_LINES; i++) begin
            pattern_mem[i] = 16'hffff;  // End marker past the last line
        end
        $readmemh("tb/hand_patterns.txt", pattern_mem);

        repeat (16) @(posedge clk_in);
        rst_in <= 1'b0;
        @(posedge clk_in);
        check_reset_state();

        line_idx = 0;
        while (!timed_out && line_idx < MAX_LINES && pattern_mem[3 * line_idx] != 16'hffff) begin
            line_mask = pattern_mem[3 * line_idx][3:0];
            line_count = int'(pattern_mem[3 * line_idx + 1]);
            line_delay = int'(pattern_mem[3 * line_idx + 2]);
            run_line(line_mask, line_count, line_delay);
            line_idx++;
        end
        if (line_idx == 0) begin
            $display("No stimulus lines were read from tb/hand_patterns.txt");
            other_errors++;
        end

        $display("Summary: %0d lines, %0d reports, %0d value, %0d handshake, %0d other errors",
                 line_idx, reports_checked, value_errors, proto_errors, other_errors);
        if (value_errors == 0 && proto_errors == 0 && other_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* tb/hand_patterns.txt */
// Columns, all hex: button mask (bit 0 left, 1 right, 2 up, 3 down),
// reports to collect, ack delay in clock cycles
2 3 0
1 3 0
4 2 0
8 2 0
3 3 0
c 3 0
0 0 0
5 2 0
a 2 0
6 2 0
9 2 0
0 0 0
1 44 0
2 44 0
0 0 0
8 32 0
4 32 0
0 0 0
7 4 0
b 4 0
d 4 0
e 4 0
f 4 0
0 0 0
2 6 c8
8 5 100
1 4 80
4 5 c8
a 3 180
5 3 400
0 0 0
2 5 0
8 4 40
0 0 0
4 18 0
8 18 0
1 8 0
2 8 0
3 2 20
c 2 20
0 0 0
6 10 96
9 10 0
a 12 0
5 12 0
0 0 0

/* sim.f */
rtl/hand_pkg.sv
rtl/button_debounce.sv
rtl/hand_controller.sv
rtl/hand_report.sv
rtl/hand_top.sv
tb/hand_tb.sv

/* Makefile */
SIM        := verilator
TOP        := hand_tb
FILELIST   := sim.f
BUILD_DIR  := obj_dir
LOG        := sim.log
FAIL_MSG   := tests failed
SIM_FLAGS  := --binary --timing --timescale 1ns/1ns -Wno-fatal
LINT_FLAGS := --lint-only --timing --timescale 1ns/1ns -Wall

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
